/* mem_return.f */
+incdir+include
logic/mem_return_pkg.sv
logic/tag_alloc.sv
logic/bank_pipe.sv
logic/returner.sv
logic/mem_return_top.sv
testbench/mem_return_sva.sv
testbench/mem_return_tb.sv

/* Makefile */
# build the testbench with Verilator, run it, and look for the pass line in the log
TOP = mem_return_tb

all: run

run:
	verilator --binary --timing --assert -f mem_return.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing -f mem_return.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* testbench/mem_return_tb.sv */
`timescale 1ns/1ps
`include "mem_return_cfg.svh"

module mem_return_tb;

	localparam int TIMEOUT = 300;              // cycles that any single wait may take
	localparam int POOL    = 1 << `MR_TAG_W;   // outstanding requests per kind

	logic                     clk = 1'b0;
	logic                     rst;
	logic                     valid;
	mem_return_pkg::mem_req_s req;
	logic                     busy;
	logic                     read_done;
	logic                     write_done;
	mem_return_pkg::data_t    rd_data;

	mem_return_pkg::data_t ref_mem [1 << `MR_ADDR_W];   // memory contents in issue order
	mem_return_pkg::data_t exp_rd [$];                  // read data still to come back
	mem_return_pkg::addr_t written [$];                 // addresses that hold a known value
	int    exp_wr;     // writes still to retire
	int    model_rd;   // reads accepted and not yet retired
	int    model_wr;
	int    errors;
	int    timeouts;
	int    rd_seen;
	int    wr_seen;
	int    seed;
	string test_name;

	mem_return_top DUT (.clk(clk), .rst(rst), .valid(valid), .req(req), .busy(busy),
		.read_done(read_done), .write_done(write_done), .rd_data(rd_data));

	always #50 clk = ~clk;

	// a pool grows on the edge that takes a request and shrinks on the edge that sees its done
	always @(posedge clk) begin
		if (rst) begin
			model_rd <= 0;
			model_wr <= 0;
		end else begin
			model_rd <= model_rd + int'(valid && !req.write) - int'(read_done);
			model_wr <= model_wr + int'(valid && req.write) - int'(write_done);
		end
	end

	task automatic compare_data(input string name, input mem_return_pkg::data_t exp,
		input mem_return_pkg::data_t act);
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_count(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	function automatic mem_return_pkg::addr_t addr_of(input int word, input int bank);
		return {mem_return_pkg::word_t'(word), mem_return_pkg::bank_t'(bank)};
	endfunction

	// pool state after the coming edge, the request now on the inputs included
	function automatic logic full_next();
		int rd_next;
		int wr_next;
		rd_next = model_rd + int'(valid && !req.write) - int'(read_done);
		wr_next = model_wr + int'(valid && req.write) - int'(write_done);
		return (rd_next >= POOL) || (wr_next >= POOL);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// monitor, outputs are settled at the falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic watch_done();
		forever begin
			@(negedge clk);
			if (!rst) begin
				// busy must follow a full pool exactly
				compare_count({test_name, " busy"}, int'(model_rd == POOL || model_wr == POOL),
					int'(busy));
				if (read_done) begin
					rd_seen++;
					if (exp_rd.size() == 0) begin
						errors++;
						$display("%s: read_done arrived with no read outstanding", test_name);
					end else begin
						compare_data(test_name, exp_rd.pop_front(), rd_data);
					end
				end
				if (write_done) begin
					wr_seen++;
					if (exp_wr == 0) begin
						errors++;
						$display("%s: write_done arrived with no write outstanding", test_name);
					end else begin
						exp_wr--;
					end
				end
			end
		end
	endtask

	// drives one request as soon as the pools leave room, valid stays high for the next call
	task automatic send(input logic write, input mem_return_pkg::addr_t addr,
		input mem_return_pkg::data_t data);
		int waited;
		waited = 0;
		@(negedge clk);
		while (full_next()) begin
			@(posedge clk);
			valid <= 1'b0;
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				timeouts++;
				$display("%s: busy stayed high for too long", test_name);
				return;
			end
		end
		@(posedge clk);
		valid     <= 1'b1;
		req.write <= write;
		req.addr  <= addr;
		req.data  <= write ? data : '0;
		if (write) begin
			ref_mem[addr] = data;
			written.push_back(addr);
			exp_wr++;
		end else begin
			exp_rd.push_back(ref_mem[addr]);   // same bank keeps order, so earlier writes count
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clk);
		valid <= 1'b0;
		while (exp_rd.size() != 0 || exp_wr != 0) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				timeouts++;
				$display("%s: done pulses stopped before all requests retired", test_name);
				return;
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic write_then_read();
		int rd0;
		int wr0;
		test_name = "write_then_read";
		rd0 = rd_seen;
		wr0 = wr_seen;
		for (int w = 0; w < 8; w++) begin
			send(1'b1, addr_of(w, 0), 32'hc0de_0000 ^ (w * 32'h0001_0203));
		end
		for (int w = 0; w < 8; w++) begin
			send(1'b0, addr_of(w, 0), '0);
		end
		drain();
		compare_count("write_then_read reads", 8, rd_seen - rd0);
		compare_count("write_then_read writes", 8, wr_seen - wr0);
	endtask

	// bank 0 answers six cycles before bank 3, yet bank 3 data is expected first
	task automatic reorder_reads();
		test_name = "reorder_reads";
		send(1'b1, addr_of(5, 3), 32'h3333_5555);
		send(1'b1, addr_of(5, 0), 32'h0000_5555);
		drain();
		send(1'b0, addr_of(5, 3), '0);
		send(1'b0, addr_of(5, 0), '0);
		drain();
	endtask

	task automatic random_traffic();
		int rd0;
		int wr0;
		int n_rd;
		int n_wr;
		test_name = "random_traffic";
		rd0 = rd_seen;
		wr0 = wr_seen;
		n_rd = 0;
		n_wr = 0;
		for (int i = 0; i < 200; i++) begin
			if (written.size() == 0 || $random(seed) % 2 == 0) begin
				send(1'b1, mem_return_pkg::addr_t'($random(seed)),
					mem_return_pkg::data_t'($random(seed)));
				n_wr++;
			end else begin
				send(1'b0, written[$unsigned($random(seed)) % written.size()], '0);
				n_rd++;
			end
		end
		drain();
		compare_count("random_traffic reads", n_rd, rd_seen - rd0);
		compare_count("random_traffic writes", n_wr, wr_seen - wr0);
	endtask

	// back to back reads into the slowest bank, the monitor ties busy to the read pool
	task automatic busy_backpressure();
		test_name = "busy_backpressure";
		for (int w = 0; w < 16; w++) begin
			send(1'b1, addr_of(w, 3), 32'hb3b3_0000 + w);
		end
		drain();
		for (int i = 0; i < 48; i++) begin
			send(1'b0, addr_of(i % 16, 3), '0);
		end
		drain();
		@(negedge clk);   // pool model and busy settle after the edge that saw the last done
		compare_count("busy_backpressure pool", 0, model_rd);
		compare_count("busy_backpressure busy", 0, int'(busy));
	endtask

	task automatic reset_in_flight();
		int rd0;
		int wr0;
		test_name = "reset_in_flight";
		for (int i = 0; i < 6; i++) begin
			send(1'b1, addr_of(i, 3 - i % 4), 32'hdead_0000 + i);
			send(1'b0, addr_of(i, 3 - i % 4), '0);
		end
		@(posedge clk);
		valid <= 1'b0;
		rst   <= 1'b1;   // bank 3 still holds requests here
		repeat (3) @(posedge clk);
		exp_rd.delete();
		exp_wr = 0;
		written.delete();
		rst <= 1'b0;
		rd0 = rd_seen;
		wr0 = wr_seen;
		repeat (20) @(posedge clk);
		compare_count("reset_in_flight stray reads", 0, rd_seen - rd0);
		compare_count("reset_in_flight stray writes", 0, wr_seen - wr0);
		for (int w = 0; w < 6; w++) begin
			send(1'b1, addr_of(w, w % 4), 32'h0f0f_0000 + w);
		end
		for (int w = 0; w < 6; w++) begin
			send(1'b0, addr_of(w, w % 4), '0);
		end
		drain();
		compare_count("reset_in_flight reads", 6, rd_seen - rd0);
		compare_count("reset_in_flight writes", 6, wr_seen - wr0);
	endtask

	initial begin
		rst       = 1'b1;
		valid     = 1'b0;
		req       = '0;
		seed      = 32'hca80bc98;
		errors    = 0;
		timeouts  = 0;
		rd_seen   = 0;
		wr_seen   = 0;
		exp_wr    = 0;
		test_name = "reset";
		fork
			watch_done();
		join_none
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		write_then_read();
		reorder_reads();
		random_traffic();
		busy_backpressure();
		reset_in_flight();
		errors = errors + DUT.u_sva.fails;
		$display("errors %0d, timeouts %0d, read_done %0d, write_done %0d",
			errors, timeouts, rd_seen, wr_seen);
		if (errors == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* testbench/mem_return_sva.sv */
`timescale 1ns/1ps
`include "mem_return_cfg.svh"

module mem_return_sva (
	input logic                        clk,
	input logic                        rst,
	input logic                        valid,
	input logic                        busy,
	input logic                        read_done,
	input logic                        write_done,
	input mem_return_pkg::completion_s cpl [`MR_BANKS]
);

	int fails = 0;   // failed assertion count, the testbench adds it to its own

	// the requester holds valid low while either pool is full
	assert property (@(posedge clk) disable iff (rst) !(valid && busy))
	else begin
		fails++;
		$error("valid was high while busy was high");
	end

	// a reset edge leaves busy and both done pulses low
	assert property (@(posedge clk) rst |=> (!busy && !read_done && !write_done))
	else begin
		fails++;
		$error("busy or a done pulse high right after reset");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tag uniqueness across banks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar i = 0; i < `MR_BANKS; i++) begin : g_i
		for (genvar j = i + 1; j < `MR_BANKS; j++) begin : g_j
			// a live tag belongs to one request, so two banks never return it together
			assert property (@(posedge clk) disable iff (rst)
				!(cpl[i].valid && cpl[j].valid && (cpl[i].write == cpl[j].write)
					&& (cpl[i].tag == cpl[j].tag)))
			else begin
				fails++;
				$error("two banks completed the same kind and tag in one cycle");
			end
		end
	end

endmodule

bind mem_return_top mem_return_sva u_sva (
	.clk        (clk),
	.rst        (rst),
	.valid      (valid),
	.busy       (busy),
	.read_done  (read_done),
	.write_done (write_done),
	.cpl        (cpl)
);

/* logic/mem_return_top.sv */
`timescale 1ns/1ps
`include "mem_return_cfg.svh"

module mem_return_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     valid,
	input  mem_return_pkg::mem_req_s req,
	output logic                     busy,
	output logic                     read_done,
	output logic                     write_done,
	output mem_return_pkg::data_t    rd_data
);

	mem_return_pkg::tagged_req_s issue;               // shared by all banks
	logic [`MR_BANKS-1:0]        bank_sel;            // one-hot, picks the bank that takes issue
	mem_return_pkg::completion_s cpl [`MR_BANKS];     // one completion port per bank

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1, tags and bank select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// done pulses loop back so the outstanding counts drain
	tag_alloc u_tag_alloc (
		.clk        (clk),
		.rst        (rst),
		.valid      (valid),
		.req        (req),
		.read_done  (read_done),
		.write_done (write_done),
		.busy       (busy),
		.issue      (issue),
		.bank_sel   (bank_sel)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2, banks with growing latency
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	generate
		for (genvar b = 0; b < `MR_BANKS; b++) begin : g_bank
			// higher banks are slower, which is where the reordering comes from
			bank_pipe #(
				.LATENCY (`MR_LAT_BASE + b * `MR_LAT_STEP)
			) u_bank (
				.clk   (clk),
				.rst   (rst),
				.sel   (bank_sel[b]),
				.issue (issue),
				.cpl   (cpl[b])
			);
		end
	endgenerate

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 3, back into issue order
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	returner u_returner (
		.clk        (clk),
		.rst        (rst),
		.cpl        (cpl),
		.read_done  (read_done),
		.write_done (write_done),
		.rd_data    (rd_data)
	);

endmodule

/* logic/returner.sv */
`timescale 1ns/1ps
`include "mem_return_cfg.svh"

module returner (
	input  logic                        clk,
	input  logic                        rst,
	input  mem_return_pkg::completion_s cpl [`MR_BANKS],
	output logic                        read_done,
	output logic                        write_done,
	output mem_return_pkg::data_t       rd_data
);

	localparam int TAGS = 1 << `MR_TAG_W;

	// read table keeps a valid bit plus the read data per tag
	logic [TAGS-1:0]       rd_vld;
	mem_return_pkg::data_t rd_mem [TAGS];

	// write table only has to remember that the write finished
	logic [TAGS-1:0]       wr_vld;

	mem_return_pkg::tag_t  rd_head;   // oldest read not yet retired
	mem_return_pkg::tag_t  wr_head;   // oldest write not yet retired
	logic                  rd_ret;    // head read is back and leaves this cycle
	logic                  wr_ret;
	logic [TAGS-1:0]       rd_set;    // reads arriving this cycle, one bit per tag
	logic [TAGS-1:0]       wr_set;
	logic [TAGS-1:0]       rd_clr;    // one-hot head entry being retired
	logic [TAGS-1:0]       wr_clr;

	// only entries stored on an earlier edge are looked at, so arrivals wait one cycle
	assign rd_ret = rd_vld[rd_head];
	assign wr_ret = wr_vld[wr_head];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arrival and retire decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// all banks can answer in the same cycle, live tags are unique within a kind
	always_comb begin
		rd_set = '0;
		wr_set = '0;
		for (int b = 0; b < `MR_BANKS; b++) begin
			if (cpl[b].valid) begin
				if (cpl[b].write) begin
					wr_set[cpl[b].tag] = 1'b1;
				end else begin
					rd_set[cpl[b].tag] = 1'b1;
				end
			end
		end
	end

	always_comb begin
		rd_clr = '0;
		wr_clr = '0;
		rd_clr[rd_head] = rd_ret;
		wr_clr[wr_head] = wr_ret;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tables
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a tag only comes back after it retired, so set and clear never hit one entry
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_vld <= '0;
			wr_vld <= '0;
		end else begin
			rd_vld <= (rd_vld & ~rd_clr) | rd_set;
			wr_vld <= (wr_vld & ~wr_clr) | wr_set;
		end
	end

	// read data lands next to its valid bit, written entries are guarded by rd_vld
	always_ff @(posedge clk) begin
		for (int b = 0; b < `MR_BANKS; b++) begin
			if (cpl[b].valid && !cpl[b].write) begin
				rd_mem[cpl[b].tag] <= cpl[b].data;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// in-order retire, at most one read and one write per cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_head    <= '0;
			wr_head    <= '0;
			read_done  <= 1'b0;
			write_done <= 1'b0;
			rd_data    <= '0;
		end else begin
			read_done  <= rd_ret;   // done pulses also free a tag in tag_alloc
			write_done <= wr_ret;
			if (rd_ret) begin
				rd_data <= rd_mem[rd_head];
				rd_head <= rd_head + mem_return_pkg::tag_t'(1);
			end else begin
				rd_data <= '0;   // data is zero between read pulses
			end
			if (wr_ret) begin
				wr_head <= wr_head + mem_return_pkg::tag_t'(1);
			end
		end
	end

endmodule

/* logic/bank_pipe.sv */
`timescale 1ns/1ps
`include "mem_return_cfg.svh"

module bank_pipe #(
	parameter int LATENCY = 2   // cycles from issue to completion, at least 2
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        sel,
	input  mem_return_pkg::tagged_req_s issue,
	output mem_return_pkg::completion_s cpl
);

	localparam int STAGES = LATENCY - 1;        // delay registers in front of the access
	localparam int WORDS  = 1 << `MR_WORD_W;    // words held by one bank

	logic [STAGES-1:0]           vld_q;            // one valid bit per delay stage
	mem_return_pkg::tagged_req_s req_q [STAGES];   // request travelling with each valid bit
	mem_return_pkg::data_t       mem [WORDS];      // bank storage, unknown until written
	mem_return_pkg::tagged_req_s last;             // oldest request, accessed at the next edge
	logic                        last_vld;
	mem_return_pkg::word_t       word;

	assign last     = req_q[STAGES-1];
	assign last_vld = vld_q[STAGES-1];
	assign word     = last.req.addr[`MR_ADDR_W-1:`MR_BANK_W];   // bank bits already chose this bank

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// delay line
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= '0;   // requests in flight are dropped
		end else begin
			vld_q[0] <= sel;
			for (int i = 1; i < STAGES; i++) begin
				vld_q[i] <= vld_q[i-1];
			end
		end
	end

	// the payload shifts every cycle, stale entries sit under a cleared valid bit
	always_ff @(posedge clk) begin
		req_q[0] <= issue;
		for (int i = 1; i < STAGES; i++) begin
			req_q[i] <= req_q[i-1];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// access stage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one request per stage, so a read never meets a write to the array in one cycle
	always_ff @(posedge clk) begin
		if (last_vld && last.req.write) begin
			mem[word] <= last.req.data;
		end
	end

	// requests leave in the order they came, a later read sees an earlier write
	always_ff @(posedge clk) begin
		if (rst) begin
			cpl.valid <= 1'b0;
		end else begin
			cpl.valid <= last_vld;
		end
		if (last_vld) begin
			cpl.write <= last.req.write;
			cpl.tag   <= last.tag;
			cpl.data  <= last.req.write ? '0 : mem[word];   // writes report zero data
		end
	end

endmodule

/* logic/tag_alloc.sv */
`timescale 1ns/1ps
`include "mem_return_cfg.svh"

module tag_alloc (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        valid,
	input  mem_return_pkg::mem_req_s    req,
	input  logic                        read_done,
	input  logic                        write_done,
	output logic                        busy,
	output mem_return_pkg::tagged_req_s issue,
	output logic [`MR_BANKS-1:0]        bank_sel
);

	// outstanding counts are one bit wider than a tag so a full pool reads as 16
	typedef logic [`MR_TAG_W:0] out_cnt_t;

	localparam out_cnt_t OUT_FULL = out_cnt_t'(1 << `MR_TAG_W);

	mem_return_pkg::tag_t  rd_tag;   // tag that the next read gets
	mem_return_pkg::tag_t  wr_tag;   // tag that the next write gets
	out_cnt_t              rd_out;   // reads issued and not yet retired
	out_cnt_t              wr_out;   // writes issued and not yet retired
	mem_return_pkg::bank_t bank;
	logic                  rd_acc;
	logic                  wr_acc;

	// the requester keeps valid low while busy, so every strobe is accepted
	assign rd_acc = valid && !req.write;
	assign wr_acc = valid && req.write;
	assign bank   = req.addr[`MR_BANK_W-1:0];   // banks interleave on the low address bits

	// either pool full stops all traffic, reads and writes share one requester
	assign busy = (rd_out == OUT_FULL) || (wr_out == OUT_FULL);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tags and outstanding counts
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_tag <= '0;
			wr_tag <= '0;
		end else begin
			if (rd_acc) begin
				rd_tag <= rd_tag + mem_return_pkg::tag_t'(1);   // wraps at 16, the returner head wraps the same way
			end
			if (wr_acc) begin
				wr_tag <= wr_tag + mem_return_pkg::tag_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_out <= '0;
			wr_out <= '0;
		end else begin
			case ({rd_acc, read_done})
				2'b10:   rd_out <= rd_out + out_cnt_t'(1);
				2'b01:   rd_out <= rd_out - out_cnt_t'(1);
				default: rd_out <= rd_out;   // one in and one out cancel
			endcase
			case ({wr_acc, write_done})
				2'b10:   wr_out <= wr_out + out_cnt_t'(1);
				2'b01:   wr_out <= wr_out - out_cnt_t'(1);
				default: wr_out <= wr_out;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// issue register, one cycle after the accepting edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			bank_sel <= '0;
		end else begin
			bank_sel <= '0;   // one-hot, zero on idle cycles
			if (valid) begin
				bank_sel[bank] <= 1'b1;
			end
		end
	end

	// payload only moves on an accepted request, bank_sel says when it counts
	always_ff @(posedge clk) begin
		if (valid) begin
			issue.req <= req;
			issue.tag <= req.write ? wr_tag : rd_tag;
		end
	end

endmodule

/* logic/mem_return_pkg.sv */
`include "mem_return_cfg.svh"

package mem_return_pkg;

	typedef logic [`MR_DATA_W-1:0] data_t;   // one memory word
	typedef logic [`MR_ADDR_W-1:0] addr_t;   // {word, bank}
	typedef logic [`MR_BANK_W-1:0] bank_t;   // low address bits
	typedef logic [`MR_WORD_W-1:0] word_t;   // upper address bits, index into one bank
	typedef logic [`MR_TAG_W-1:0]  tag_t;    // issue order within one kind

	// plain request as the requester sends it
	typedef struct packed {
		logic  write;   // 1 for a write, 0 for a read
		addr_t addr;
		data_t data;    // only meaningful for a write
	} mem_req_s;

	// request after tag allocation, the tag counts reads and writes separately
	typedef struct packed {
		mem_req_s req;
		tag_t     tag;
	} tagged_req_s;

	// what a bank hands back to the returner
	typedef struct packed {
		logic  valid;
		logic  write;   // kind of the finished request, picks the table in the returner
		tag_t  tag;
		data_t data;    // read result, zero for a write
	} completion_s;

endpackage

/* include/mem_return_cfg.svh */
`ifndef MEM_RETURN_CFG_SVH
`define MEM_RETURN_CFG_SVH

// width of one memory word and of every read result
`define MR_DATA_W 32

// full request address, bank number in the low bits and the word index above them
`define MR_ADDR_W 6

// bank count, each bank answers with its own fixed latency
`define MR_BANKS 4

// address bits spent on the bank number, the rest picks the word inside a bank
`define MR_BANK_W $clog2(`MR_BANKS)
`define MR_WORD_W (`MR_ADDR_W - `MR_BANK_W)

// order tags, 16 reads and 16 writes may be in flight
`define MR_TAG_W 4

// bank b answers MR_LAT_BASE + b * MR_LAT_STEP cycles after issue
`define MR_LAT_BASE 2
`define MR_LAT_STEP 2

`endif
